/* tb.f */
source/tetris_ai_pkg.sv
source/ai_feature_if.sv
source/ai_move_sequencer.sv
source/ai_placement_eval.sv
source/ai_best_move.sv
source/tetris_ai_top.sv
verif/tb_tetris_ai.sv

/* Makefile */
TOP = tb_tetris_ai
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/tb_tetris_ai.sv */
`timescale 1ns/100ps

module tb_tetris_ai;

    typedef logic [tetris_ai_pkg::BOARD_H-1:0][tetris_ai_pkg::BOARD_W-1:0] board_t;

    localparam int NUM_FIXED   = 11;
    localparam int NUM_RANDOM  = 6;
    localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
    localparam int CLK_NS      = 10;

    logic                                clk;
    logic                                rst;
    logic                                start_i;
    logic [tetris_ai_pkg::PIECE_W-1:0]   piece_i;
    board_t                              board_i;
    logic                                busy_o;
    logic                                done_o;
    logic [tetris_ai_pkg::X_W-1:0]       best_x_o;
    logic [tetris_ai_pkg::TYPE_W-1:0]    best_type_o;
    logic [tetris_ai_pkg::SCORE_W-1:0]   best_score_o;

    board_t board_tab  [NUM_ENTRIES];
    int     piece_tab  [NUM_ENTRIES];
    int     extra_tab  [NUM_ENTRIES];                     // Start pulse while busy, 0 for none.
    int     hand_x     [NUM_ENTRIES];
    int     hand_type  [NUM_ENTRIES];
    int     hand_score [NUM_ENTRIES];                     // Worked by hand, -1 when absent.
    int     exp_x      [NUM_ENTRIES];
    int     exp_type   [NUM_ENTRIES];
    int     exp_score  [NUM_ENTRIES];
    int     exp_n      [NUM_ENTRIES];
    int     n_entries;
    int     errors;
    int     checks;
    integer seed;
    longint budget_ns;
    bit     budget_ready = 1'b0;

    tetris_ai_top DUT (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .piece_i      (piece_i),
        .board_i      (board_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .best_x_o     (best_x_o),
        .best_type_o  (best_type_o),
        .best_score_o (best_score_o)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, what);
        end
    endtask

    function automatic int sat_byte(input int v);
        return (v > 255) ? 255 : v;
    endfunction

    // Column c gets a solid stack of nib[4c+3:4c] cells.
    function automatic board_t board_from_heights(input logic [39:0] nib);
        board_t b;
        b = '0;
        for (int c = 0; c < tetris_ai_pkg::BOARD_W; c++) begin
            for (int r = 0; r < int'(nib[4*c +: 4]); r++) begin
                b[r][c] = 1'b1;
            end
        end
        return b;
    endfunction

    // Straight drop to the lowest free offset, then the weighted features.
    function automatic int placement_score(input board_t board, input int o, input int x);
        board_t      grid;
        logic [15:0] mask;
        int          land;
        int          hgt [tetris_ai_pkg::BOARD_W];
        int          lines;
        int          agg;
        int          holes;
        int          bump;
        bit          hit;
        mask  = tetris_ai_pkg::ORIENT_MASK[o];
        land  = -1;
        lines = 0;
        agg   = 0;
        holes = 0;
        bump  = 0;
        for (int r = 0; r <= tetris_ai_pkg::BOARD_H - 4 && land < 0; r++) begin
            hit = 1'b0;
            for (int k = 0; k < 4; k++) begin
                for (int j = 0; j < 4; j++) begin
                    if (mask[4*k+j] && board[r+k][x+j]) hit = 1'b1;
                end
            end
            if (!hit) land = r;
        end
        if (land < 0) land = tetris_ai_pkg::BOARD_H - 4;   // No fit, piece sits on top.
        grid = board;
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                if (mask[4*k+j]) grid[land+k][x+j] = 1'b1;
            end
        end
        for (int r = 0; r < tetris_ai_pkg::BOARD_H; r++) begin
            if (&grid[r]) lines++;
        end
        for (int c = 0; c < tetris_ai_pkg::BOARD_W; c++) begin
            hgt[c] = 0;
            for (int r = 0; r < tetris_ai_pkg::BOARD_H; r++) begin
                if (grid[r][c]) hgt[c] = r + 1;
            end
            agg += hgt[c];
            for (int r = 0; r < hgt[c]; r++) begin
                if (!grid[r][c]) holes++;
            end
        end
        for (int c = 0; c < tetris_ai_pkg::BOARD_W - 1; c++) begin
            bump += (hgt[c] > hgt[c+1]) ? hgt[c] - hgt[c+1] : hgt[c+1] - hgt[c];
        end
        return int'(tetris_ai_pkg::W_HEIGHTS) * sat_byte(agg)
             + int'(tetris_ai_pkg::W_HOLES) * sat_byte(holes)
             + int'(tetris_ai_pkg::W_BUMP) * sat_byte(bump)
             + int'(tetris_ai_pkg::W_LINES) * sat_byte(lines);
    endfunction

    // Orientation outer, X inner, strictly lower score wins.
    task automatic model_entry(input int idx);
        int first;
        int sc;
        first          = int'(tetris_ai_pkg::PIECE_FIRST[piece_tab[idx]]);
        exp_x[idx]     = 0;
        exp_type[idx]  = 0;
        exp_score[idx] = int'(tetris_ai_pkg::SCORE_MAX);
        exp_n[idx]     = 0;
        for (int o = first; o < first + int'(tetris_ai_pkg::PIECE_COUNT[piece_tab[idx]]); o++) begin
            for (int x = 0; x <= tetris_ai_pkg::BOARD_W - int'(tetris_ai_pkg::ORIENT_WIDTH[o]); x++) begin
                exp_n[idx]++;
                sc = placement_score(board_tab[idx], o, x);
                if (sc < exp_score[idx]) begin
                    exp_score[idx] = sc;
                    exp_x[idx]     = x;
                    exp_type[idx]  = o;
                end
            end
        end
    endtask

    task automatic add_entry(input board_t b, input int piece, input int extra,
                             input int hx, input int ht, input int hs);
        board_tab[n_entries]  = b;
        piece_tab[n_entries]  = piece;
        extra_tab[n_entries]  = extra;
        hand_x[n_entries]     = hx;
        hand_type[n_entries]  = ht;
        hand_score[n_entries] = hs;
        n_entries++;
    endtask

    task automatic load_table();
        board_t b;
        int     h;
        n_entries = 0;
        b = '0;
        add_entry(b, 0, 0, 0, 0, 26);                        // I flat at the left wall.
        add_entry(b, 1, 0, 0, 2, 28);                        // O at the left wall.
        for (int p = 2; p < tetris_ai_pkg::NUM_PIECES; p++) begin
            add_entry(b, p, 0, 0, 0, -1);
        end
        b[0] = 10'h3DF;                                      // Bottom row open at column 5.
        for (int r = 1; r <= 4; r++) begin
            b[r] = 10'h050;                                  // Walls beside the gap.
        end
        add_entry(b, 0, 0, 5, 1, 158);                       // Upright I clears one line.
        b    = '0;
        b[0] = 10'h3F3;
        b[1] = 10'h3C3;
        b[2] = 10'h03C;                                      // Overhang over empty cells.
        add_entry(b, 2, 0, 0, 0, -1);
        add_entry(board_from_heights(40'h3105224013), 5, 3, 0, 0, -1);
        add_entry(board_from_heights(40'h0281736405), 6, 5, 0, 0, -1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            b = '0;
            for (int c = 0; c < tetris_ai_pkg::BOARD_W; c++) begin
                h = {$random(seed)} % 9;
                for (int r = 0; r < h; r++) begin
                    b[r][c] = (({$random(seed)} % 6) != 0) || (r == h - 1);
                end
            end
            add_entry(b, {$random(seed)} % 7, {$random(seed)} % 4, 0, 0, -1);
        end
    endtask

    task automatic run_search(input int idx);
        int cycles;
        bit seen;
        @(negedge clk);
        board_i = board_tab[idx];
        piece_i = tetris_ai_pkg::PIECE_W'(piece_tab[idx]);
        start_i = 1'b1;
        cycles  = 0;
        seen    = 1'b0;
        while (!seen && cycles < exp_n[idx] + 10) begin
            @(negedge clk);
            cycles++;
            start_i = (cycles == extra_tab[idx]);            // Extra start lands while busy.
            check(busy_o == (cycles <= exp_n[idx]),
                  $sformatf("entry %0d busy_o %0b in cycle %0d", idx, busy_o, cycles));
            seen = done_o;
        end
        checks++;
        assert (seen) else begin
            errors++;
            $display("Entry %0d: done_o did not pulse within %0d cycles of start_i", idx, cycles);
        end
        if (seen) begin
            check(cycles == exp_n[idx] + 2,
                  $sformatf("entry %0d done after %0d cycles, expected %0d",
                            idx, cycles, exp_n[idx] + 2));
            check(int'(best_x_o) == exp_x[idx] && int'(best_type_o) == exp_type[idx],
                  $sformatf("entry %0d move x %0d type %0d, expected x %0d type %0d",
                            idx, best_x_o, best_type_o, exp_x[idx], exp_type[idx]));
            check(int'(best_score_o) == exp_score[idx],
                  $sformatf("entry %0d score %0d, expected %0d",
                            idx, best_score_o, exp_score[idx]));
            if (hand_score[idx] >= 0) begin
                check(int'(best_x_o) == hand_x[idx] && int'(best_type_o) == hand_type[idx]
                      && int'(best_score_o) == hand_score[idx],
                      $sformatf("entry %0d move differs from the worked example", idx));
            end
            @(negedge clk);
            check(!done_o, $sformatf("entry %0d done_o high for two cycles", idx));
        end
    endtask

    initial begin : watchdog
        wait (budget_ready);
        #(budget_ns);
        $display("Timeout: the searches did not finish within %0d ns", budget_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        errors  = 0;
        checks  = 0;
        seed    = 32'hc757_e504;
        rst     = 1'b1;
        start_i = 1'b0;
        piece_i = '0;
        board_i = '0;
        load_table();
        budget_ns = 5 * CLK_NS;
        for (int i = 0; i < n_entries; i++) begin
            model_entry(i);
            budget_ns += (exp_n[i] + 10) * CLK_NS;
        end
        budget_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check(!done_o && !busy_o, "done_o or busy_o high after reset");
        check(best_x_o == '0 && best_type_o == '0, "best move not zero after reset");
        check(best_score_o == tetris_ai_pkg::SCORE_MAX, "best score not at maximum after reset");
        for (int i = 0; i < n_entries; i++) begin
            run_search(i);
        end
        $display("Checks run: %0d, checks failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* source/tetris_ai_top.sv */
`timescale 1ns/100ps

module tetris_ai_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start_i,
    input  logic [tetris_ai_pkg::PIECE_W-1:0]  piece_i,
    input  logic [tetris_ai_pkg::BOARD_H-1:0][tetris_ai_pkg::BOARD_W-1:0] board_i,
    output logic                               busy_o,
    output logic                               done_o,
    output logic [tetris_ai_pkg::X_W-1:0]      best_x_o,
    output logic [tetris_ai_pkg::TYPE_W-1:0]   best_type_o,
    output logic [tetris_ai_pkg::SCORE_W-1:0]  best_score_o
);

    logic                             search_start;
    logic                             cand_valid;
    logic                             cand_last;
    logic [tetris_ai_pkg::X_W-1:0]    cand_x;
    logic [tetris_ai_pkg::TYPE_W-1:0] cand_type;

    ai_feature_if feat_if ();                                // One scored candidate.

    ai_move_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .piece_i        (piece_i),
        .busy_o         (busy_o),
        .search_start_o (search_start),
        .cand_valid_o   (cand_valid),
        .cand_last_o    (cand_last),
        .cand_x_o       (cand_x),
        .cand_type_o    (cand_type)
    );

    ai_placement_eval u_eval (
        .clk          (clk),
        .rst          (rst),
        .board_i      (board_i),
        .cand_valid_i (cand_valid),
        .cand_last_i  (cand_last),
        .cand_x_i     (cand_x),
        .cand_type_i  (cand_type),
        .feat         (feat_if.producer)
    );

    ai_best_move u_best (
        .clk            (clk),
        .rst            (rst),
        .search_start_i (search_start),
        .feat           (feat_if.consumer),
        .best_x_o       (best_x_o),
        .best_type_o    (best_type_o),
        .best_score_o   (best_score_o),
        .done_o         (done_o)
    );

endmodule

/* source/ai_best_move.sv */
`timescale 1ns/100ps

module ai_best_move (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               search_start_i,
    ai_feature_if.consumer                     feat,
    output logic [tetris_ai_pkg::X_W-1:0]      best_x_o,
    output logic [tetris_ai_pkg::TYPE_W-1:0]   best_type_o,
    output logic [tetris_ai_pkg::SCORE_W-1:0]  best_score_o,
    output logic                               done_o
);

    logic [tetris_ai_pkg::SCORE_W-1:0] cand_score;
    logic [tetris_ai_pkg::SCORE_W-1:0] best_score_q;
    logic [tetris_ai_pkg::X_W-1:0]     best_x_q;
    logic [tetris_ai_pkg::TYPE_W-1:0]  best_type_q;
    logic                              done_q;

    function automatic logic [tetris_ai_pkg::SCORE_W-1:0] score_of(
        input logic [tetris_ai_pkg::FEAT_W-1:0] lines,
        input logic [tetris_ai_pkg::FEAT_W-1:0] bump,
        input logic [tetris_ai_pkg::FEAT_W-1:0] heights,
        input logic [tetris_ai_pkg::FEAT_W-1:0] holes
    );
        logic [tetris_ai_pkg::SCORE_W-tetris_ai_pkg::FEAT_W-1:0] pad;
        pad = '0;
        return {pad, heights} * tetris_ai_pkg::W_HEIGHTS
             + {pad, holes}   * tetris_ai_pkg::W_HOLES
             + {pad, bump}    * tetris_ai_pkg::W_BUMP
             + {pad, lines}   * tetris_ai_pkg::W_LINES;
    endfunction

    // Lower is better.
    assign cand_score = score_of(feat.lines_cleared, feat.bumpiness, feat.heights, feat.holes);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_score_q <= tetris_ai_pkg::SCORE_MAX;
            best_x_q     <= '0;
            best_type_q  <= '0;
            done_q       <= 1'b0;
        end else begin
            done_q <= feat.valid && feat.last;
            if (search_start_i) begin
                best_score_q <= tetris_ai_pkg::SCORE_MAX;    // A new search forgets the old best.
            end else if (feat.valid && (cand_score < best_score_q)) begin
                best_score_q <= cand_score;                  // Ties keep the earlier move.
                best_x_q     <= feat.block_x;
                best_type_q  <= feat.block_type;
            end
        end
    end

    assign best_x_o     = best_x_q;
    assign best_type_o  = best_type_q;
    assign best_score_o = best_score_q;
    assign done_o       = done_q;

    a_done_single: assert property (
        @(posedge clk) disable iff (rst)
        done_o |=> !done_o
    );

endmodule

/* source/ai_placement_eval.sv */
`timescale 1ns/100ps

module ai_placement_eval (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [tetris_ai_pkg::BOARD_H-1:0][tetris_ai_pkg::BOARD_W-1:0] board_i,
    input  logic                               cand_valid_i,
    input  logic                               cand_last_i,
    input  logic [tetris_ai_pkg::X_W-1:0]      cand_x_i,
    input  logic [tetris_ai_pkg::TYPE_W-1:0]   cand_type_i,
    ai_feature_if.producer                     feat
);

    logic [15:0]                                          mask;
    logic [tetris_ai_pkg::MASK_N-1:0][tetris_ai_pkg::BOARD_W-1:0] prow;    // Shifted mask rows.
    logic [tetris_ai_pkg::BOARD_H-tetris_ai_pkg::MASK_N:0] fit;
    logic [tetris_ai_pkg::ROW_W-1:0]                      land_row;
    logic [tetris_ai_pkg::BOARD_H-1:0][tetris_ai_pkg::BOARD_W-1:0] placed;
    logic [tetris_ai_pkg::BOARD_W-1:0][tetris_ai_pkg::HGT_W-1:0]   col_h;
    logic [tetris_ai_pkg::BOARD_W-2:0][tetris_ai_pkg::HGT_W-1:0]   bump_d;
    logic [tetris_ai_pkg::ACC_W-1:0]                      line_sum;
    logic [tetris_ai_pkg::ACC_W-1:0]                      height_sum;
    logic [tetris_ai_pkg::ACC_W-1:0]                      hole_sum;
    logic [tetris_ai_pkg::ACC_W-1:0]                      bump_sum;

    function automatic logic [tetris_ai_pkg::FEAT_W-1:0] sat_feat(
        input logic [tetris_ai_pkg::ACC_W-1:0] v
    );
        if (|v[tetris_ai_pkg::ACC_W-1:tetris_ai_pkg::FEAT_W]) begin
            return '1;
        end
        return v[tetris_ai_pkg::FEAT_W-1:0];
    endfunction

    // Mask rows moved to the candidate column.
    always_comb begin
        mask = '0;
        if (cand_type_i < tetris_ai_pkg::NUM_ORIENT) begin
            mask = tetris_ai_pkg::ORIENT_MASK[cand_type_i];
        end
        for (int k = 0; k < tetris_ai_pkg::MASK_N; k++) begin
            prow[k] = {{(tetris_ai_pkg::BOARD_W-tetris_ai_pkg::MASK_N){1'b0}},
                       mask[k*tetris_ai_pkg::MASK_N +: tetris_ai_pkg::MASK_N]} << cand_x_i;
        end
    end

    // Drop: lowest mask offset with no overlap, else the top rows.
    always_comb begin
        for (int r = 0; r <= tetris_ai_pkg::BOARD_H - tetris_ai_pkg::MASK_N; r++) begin
            fit[r] = 1'b1;
            for (int k = 0; k < tetris_ai_pkg::MASK_N; k++) begin
                if ((board_i[r+k] & prow[k]) != '0) begin
                    fit[r] = 1'b0;
                end
            end
        end
        land_row = tetris_ai_pkg::ROW_W'(tetris_ai_pkg::BOARD_H - tetris_ai_pkg::MASK_N);
        for (int r = tetris_ai_pkg::BOARD_H - tetris_ai_pkg::MASK_N; r >= 0; r--) begin
            if (fit[r]) begin
                land_row = r[tetris_ai_pkg::ROW_W-1:0];
            end
        end
        for (int row = 0; row < tetris_ai_pkg::BOARD_H; row++) begin
            placed[row] = board_i[row];
            for (int k = 0; k < tetris_ai_pkg::MASK_N; k++) begin
                if (row == int'(land_row) + k) begin
                    placed[row] = placed[row] | prow[k];
                end
            end
        end
    end

    // Features of the board with the piece in place.
    always_comb begin
        line_sum   = '0;
        height_sum = '0;
        hole_sum   = '0;
        bump_sum   = '0;
        for (int row = 0; row < tetris_ai_pkg::BOARD_H; row++) begin
            if (&placed[row]) begin
                line_sum = line_sum + 1'b1;                  // Rows are kept, only counted.
            end
        end
        for (int c = 0; c < tetris_ai_pkg::BOARD_W; c++) begin
            col_h[c] = '0;
            for (int row = 0; row < tetris_ai_pkg::BOARD_H; row++) begin
                if (placed[row][c]) begin
                    col_h[c] = row[tetris_ai_pkg::HGT_W-1:0] + 1'b1;
                end
            end
            height_sum = height_sum
                         + {{(tetris_ai_pkg::ACC_W-tetris_ai_pkg::HGT_W){1'b0}}, col_h[c]};
            for (int row = 0; row < tetris_ai_pkg::BOARD_H; row++) begin
                if ((row < int'(col_h[c])) && !placed[row][c]) begin
                    hole_sum = hole_sum + 1'b1;              // Empty cell under the top.
                end
            end
        end
        for (int c = 0; c < tetris_ai_pkg::BOARD_W - 1; c++) begin
            if (col_h[c] > col_h[c+1]) begin
                bump_d[c] = col_h[c] - col_h[c+1];
            end else begin
                bump_d[c] = col_h[c+1] - col_h[c];
            end
            bump_sum = bump_sum
                       + {{(tetris_ai_pkg::ACC_W-tetris_ai_pkg::HGT_W){1'b0}}, bump_d[c]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            feat.valid <= 1'b0;
            feat.last  <= 1'b0;
        end else begin
            feat.valid <= cand_valid_i;
            feat.last  <= cand_valid_i && cand_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cand_valid_i) begin
            feat.block_x       <= cand_x_i;
            feat.block_type    <= cand_type_i;
            feat.lines_cleared <= sat_feat(line_sum);
            feat.bumpiness     <= sat_feat(bump_sum);
            feat.heights       <= sat_feat(height_sum);
            feat.holes         <= sat_feat(hole_sum);
        end
    end

endmodule

/* source/ai_move_sequencer.sv */
`timescale 1ns/100ps

module ai_move_sequencer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               start_i,
    input  logic [tetris_ai_pkg::PIECE_W-1:0]  piece_i,
    output logic                               busy_o,
    output logic                               search_start_o,
    output logic                               cand_valid_o,
    output logic                               cand_last_o,
    output logic [tetris_ai_pkg::X_W-1:0]      cand_x_o,
    output logic [tetris_ai_pkg::TYPE_W-1:0]   cand_type_o
);

    tetris_ai_pkg::seq_state_e state_q;

    logic [tetris_ai_pkg::TYPE_W-1:0] orient_q;
    logic [tetris_ai_pkg::TYPE_W-1:0] orient_end_q;        // Last orientation of the piece.
    logic [tetris_ai_pkg::X_W-1:0]    x_q;
    logic [tetris_ai_pkg::X_W-1:0]    x_limit;
    logic                             run;
    logic                             x_end;
    logic                             orient_end;
    logic                             accept;
    logic                             search_start_q;

    assign run        = (state_q == tetris_ai_pkg::SEQ_RUN);
    assign x_limit    = tetris_ai_pkg::BOARD_W_X - tetris_ai_pkg::ORIENT_WIDTH[orient_q];
    assign x_end      = (x_q == x_limit);
    assign orient_end = (orient_q == orient_end_q);

    // Start is dropped while a search runs or for an unknown piece.
    assign accept = start_i && !run && (piece_i < tetris_ai_pkg::NUM_PIECES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q        <= tetris_ai_pkg::SEQ_IDLE;
            orient_q       <= '0;
            orient_end_q   <= '0;
            x_q            <= '0;
            search_start_q <= 1'b0;
        end else begin
            search_start_q <= accept;
            if (accept) begin
                state_q      <= tetris_ai_pkg::SEQ_RUN;
                orient_q     <= tetris_ai_pkg::PIECE_FIRST[piece_i];
                orient_end_q <= tetris_ai_pkg::PIECE_FIRST[piece_i]
                                + tetris_ai_pkg::PIECE_COUNT[piece_i] - 1'b1;
                x_q          <= '0;
            end else if (run) begin
                if (!x_end) begin
                    x_q <= x_q + 1'b1;
                end else if (orient_end) begin
                    state_q <= tetris_ai_pkg::SEQ_IDLE;            // Final pair issued.
                end else begin
                    orient_q <= orient_q + 1'b1;
                    x_q      <= '0;
                end
            end
        end
    end

    assign busy_o         = run;
    assign search_start_o = search_start_q;
    assign cand_valid_o   = run;
    assign cand_last_o    = run && x_end && orient_end;
    assign cand_x_o       = x_q;
    assign cand_type_o    = orient_q;

    // A candidate never hangs over the right wall.
    a_cand_in_board: assert property (
        @(posedge clk) disable iff (rst)
        cand_valid_o |-> ({1'b0, cand_x_o} + {1'b0, tetris_ai_pkg::ORIENT_WIDTH[cand_type_o]})
                         <= tetris_ai_pkg::BOARD_W
    );

endmodule

/* source/ai_feature_if.sv */
`timescale 1ns/100ps

interface ai_feature_if;

    logic                               valid;         // One strobe per candidate.
    logic                               last;          // Final candidate of a search.
    logic [tetris_ai_pkg::X_W-1:0]      block_x;
    logic [tetris_ai_pkg::TYPE_W-1:0]   block_type;
    logic [tetris_ai_pkg::FEAT_W-1:0]   lines_cleared;
    logic [tetris_ai_pkg::FEAT_W-1:0]   bumpiness;
    logic [tetris_ai_pkg::FEAT_W-1:0]   heights;
    logic [tetris_ai_pkg::FEAT_W-1:0]   holes;

    // Evaluator side.
    modport producer (
        output valid, last, block_x, block_type,
        output lines_cleared, bumpiness, heights, holes
    );

    // Chooser side, no back-pressure.
    modport consumer (
        input valid, last, block_x, block_type,
        input lines_cleared, bumpiness, heights, holes
    );

endinterface

/* source/tetris_ai_pkg.sv */
package tetris_ai_pkg;

    // Board geometry.
    localparam int BOARD_W = 10;                         // Columns.
    localparam int BOARD_H = 16;                         // Rows, row 0 is the floor.
    localparam int X_W     = 4;
    localparam int TYPE_W  = 5;
    localparam int PIECE_W = 3;
    localparam int ROW_W   = 4;                          // Row index inside the board.
    localparam int HGT_W   = 5;                          // Column height, 0 to 16.
    localparam int ACC_W   = 10;                         // Wide sums before saturation.
    localparam int MASK_N  = 4;                          // Piece masks are 4 by 4 cells.

    localparam logic [X_W-1:0] BOARD_W_X = X_W'(BOARD_W);

    // Features and score.
    localparam int FEAT_W  = 8;
    localparam int SCORE_W = 18;
    localparam logic [SCORE_W-1:0] SCORE_MAX = '1;

    localparam logic [SCORE_W-1:0] W_HEIGHTS = 18'd6;
    localparam logic [SCORE_W-1:0] W_HOLES   = 18'd4;
    localparam logic [SCORE_W-1:0] W_BUMP    = 18'd2;
    localparam logic [SCORE_W-1:0] W_LINES   = 18'd12;

    // Pieces in order I, O, T, S, Z, J, L.
    localparam int NUM_PIECES = 7;
    localparam int NUM_ORIENT = 19;

    localparam logic [TYPE_W-1:0] PIECE_FIRST [NUM_PIECES] = '{
        5'd0, 5'd2, 5'd3, 5'd7, 5'd9, 5'd11, 5'd15
    };

    localparam logic [TYPE_W-1:0] PIECE_COUNT [NUM_PIECES] = '{
        5'd2, 5'd1, 5'd4, 5'd2, 5'd2, 5'd4, 5'd4
    };

    // Cell (row, col) of a mask is bit row*4 + col.
    localparam logic [15:0] ORIENT_MASK [NUM_ORIENT] = '{
        16'h000F,                                        // I flat.
        16'h1111,                                        // I upright.
        16'h0033,                                        // O.
        16'h0072,                                        // T, stem down.
        16'h0027,                                        // T, stem up.
        16'h0131,                                        // T, stem right.
        16'h0232,                                        // T, stem left.
        16'h0063,                                        // S flat.
        16'h0132,                                        // S upright.
        16'h0036,                                        // Z flat.
        16'h0231,                                        // Z upright.
        16'h0017,                                        // J, corner up left.
        16'h0074,                                        // J, corner down right.
        16'h0223,
        16'h0311,
        16'h0047,                                        // L, corner up right.
        16'h0071,                                        // L, corner down left.
        16'h0113,
        16'h0322
    };

    localparam logic [X_W-1:0] ORIENT_WIDTH [NUM_ORIENT] = '{
        4'd4, 4'd1,
        4'd2,
        4'd3, 4'd3, 4'd2, 4'd2,
        4'd3, 4'd2,
        4'd3, 4'd2,
        4'd3, 4'd3, 4'd2, 4'd2,
        4'd3, 4'd3, 4'd2, 4'd2
    };

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

endpackage
